/* src/nora_trace_defines.svh */
// cpu phase, trace buffer depth and trace record byte constants
`ifndef NORA_TRACE_DEFINES_SVH
`define NORA_TRACE_DEFINES_SVH

// cpu clock phasing, counted in clk6x cycles
`define CPU_CYCLE_PHASES    6       // clk6x cycles per cpu cycle
`define PHI2_RISE_PHASE     3       // cphi2 goes high, address latched
`define RELEASE_WR_PHASE    5       // last phase, write data valid

// trace buffer geometry
`define TRACE_DEPTH         8       // records kept
`define TRACE_PTR_W         3       // log2 of depth

// host side record layout
`define TRACE_BYTES         5       // status, data, addr lo, addr hi, bank
`define EMPTY_READ_BYTE     8'hFF   // returned when nothing is traced

`endif

/* src/nora_trace_pkg.sv */
// trace record struct, cpu status union and fill count type
`default_nettype none

package nora_trace_pkg;

    // 65C816 reading of the status byte
    typedef struct packed {
        logic flag_x;           // index reg width, sampled at phi2 rise
        logic flag_m;           // accu width, sampled at phi2 fall
        logic vpa;              // valid program address
        logic mln_n;            // memory lock
        logic vp_n;             // vector pull
        logic vda;              // valid data address
        logic ef;               // emulation flag
        logic rw_n;
    } c816_status_t;

    // 65C02 reading of the same byte
    typedef struct packed {
        logic       sob_at_latch;   // set-overflow pin at phi2 rise
        logic       sob_at_release; // set-overflow pin at end of cycle
        logic       sync;           // opcode fetch
        logic       mln_n;
        logic       vp_n;
        logic [1:0] rsvd;           // always 11 on a C02
        logic       rw_n;
    } c02_status_t;

    // one byte, two decodings; cpu type picks the view
    typedef union packed {
        c816_status_t c816;
        c02_status_t  c02;
    } cpu_status_u;

    // five bytes; low byte goes out first
    typedef struct packed {
        logic [7:0]  bank;      // 816 bank address, 0 on C02
        logic [15:0] addr;
        logic [7:0]  data;
        cpu_status_u status;
    } trace_rec_t;

    typedef logic [3:0] trace_level_t;  // 0..8 records held

endpackage

`default_nettype wire

/* src/trace_rd_if.sv */
// trace buffer to trace reader interface with buffer and reader modports
`timescale 1ns/100ps
`default_nettype none

interface trace_rd_if;
    import nora_trace_pkg::*;

    trace_rec_t   rec;      // head record, valid while !empty
    logic         empty;
    trace_level_t level;    // records held
    logic         pop;      // one cycle, drops the head

    // storage side
    modport buffer (
        output rec,
        output empty,
        output level,
        input  pop
    );

    // host side
    modport reader (
        input  rec,
        input  empty,
        input  level,
        output pop
    );

endinterface

`default_nettype wire

/* src/cpu_phaser.sv */
// cpu clock phase generator with address latch and write release strobes
`timescale 1ns/100ps
`default_nettype none

`include "nora_trace_defines.svh"

module cpu_phaser (
    input  wire  clk6x,
    input  wire  rst_n_i,
    input  wire  run_i,             // cpu may start a new cycle
    output logic cphi2_o,           // cpu clock
    output logic latch_ad_o,        // phi2 rising edge
    output logic release_wr_o       // end of the write phase
);
    localparam int PH_W = $clog2(`CPU_CYCLE_PHASES);

    logic [PH_W-1:0] phase;
    logic [PH_W-1:0] phase_nxt;

    // stall only in phase 0, a started cycle always completes
    always_comb
    begin
        if (phase == PH_W'(`CPU_CYCLE_PHASES - 1))
            phase_nxt = '0;                 // wrap
        else if ((phase == '0) && !run_i)
            phase_nxt = '0;                 // cpu held with phi2 low
        else
            phase_nxt = phase + 1'b1;
    end

    // decoded from the next phase so outputs line up with the counter
    always_ff @(posedge clk6x or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            phase        <= '0;
            cphi2_o      <= 1'b0;
            latch_ad_o   <= 1'b0;
            release_wr_o <= 1'b0;
        end
        else
        begin
            phase        <= phase_nxt;
            cphi2_o      <= (phase_nxt >= PH_W'(`PHI2_RISE_PHASE));    // high half
            latch_ad_o   <= (phase_nxt == PH_W'(`PHI2_RISE_PHASE));
            release_wr_o <= (phase_nxt == PH_W'(`RELEASE_WR_PHASE));
        end
    end

endmodule

`default_nettype wire

/* src/cpu_bus_sampler.sv */
// cpu bus sampler with 65C02 / 65C816 forcing rules and trace record push
`timescale 1ns/100ps
`default_nettype none

module cpu_bus_sampler (
    input  wire                      clk6x,
    input  wire                      rst_n_i,
    input  wire                      latch_ad_i,    // phi2 rise
    input  wire                      release_wr_i,  // end of cycle
    input  wire                      cputype02_i,   // 1 = 65C02, 0 = 65C816
    input  wire  [15:0]              cpu_ab_i,
    input  wire  [7:0]               cpu_db_i,      // bank at phi2 rise on 816
    input  wire                      csob_mx_i,     // sob on C02, m/x on 816
    input  wire                      csync_vpa_i,
    input  wire                      cmln_i,
    input  wire                      cvpn_i,
    input  wire                      cvda_i,
    input  wire                      cef_i,
    input  wire                      crwn_i,
    output logic                     push_o,
    output nora_trace_pkg::trace_rec_t push_rec_o
);
    import nora_trace_pkg::*;

    logic        cputype02_r;
    logic [15:0] addr_r;
    logic [7:0]  bank_r;
    logic [7:0]  data_r;
    logic        flag_x_r, flag_m_r;
    logic        vpa_r, mln_r, vpn_r, vda_r, ef_r, rwn_r;
    cpu_status_u status;

    // board strap, resampled every clock
    always_ff @(posedge clk6x or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            cputype02_r <= 1'b0;
            push_o      <= 1'b0;
        end
        else
        begin
            cputype02_r <= cputype02_i;
            push_o      <= release_wr_i;    // record complete one clock later
        end
    end

    // captured bus fields
    always_ff @(posedge clk6x)
    begin
        if (latch_ad_i)
        begin
            addr_r   <= cpu_ab_i;
            bank_r   <= cputype02_r ? 8'h00 : cpu_db_i;    // C02 has no bank
            flag_x_r <= csob_mx_i | cputype02_r | cef_i;   // 8-bit index in emulation
            vpa_r    <= csync_vpa_i;
            mln_r    <= cmln_i;
            vpn_r    <= cvpn_i;
            vda_r    <= cvda_i | cputype02_r;
            ef_r     <= cef_i | cputype02_r;
            rwn_r    <= crwn_i;
        end
        if (release_wr_i)
        begin
            data_r   <= cpu_db_i;                          // write data valid now
            flag_m_r <= csob_mx_i | cputype02_r | ef_r;    // m is valid at phi2 fall
        end
    end

    // status byte built in the view of the fitted cpu
    always_comb
    begin
        if (cputype02_r)
        begin
            status.c02.sob_at_latch   = flag_x_r;
            status.c02.sob_at_release = flag_m_r;
            status.c02.sync           = vpa_r;
            status.c02.mln_n          = mln_r;
            status.c02.vp_n           = vpn_r;
            status.c02.rsvd           = 2'b11;  // vda/ef positions, forced
            status.c02.rw_n           = rwn_r;
        end
        else
        begin
            status.c816.flag_x = flag_x_r;
            status.c816.flag_m = flag_m_r;
            status.c816.vpa    = vpa_r;
            status.c816.mln_n  = mln_r;
            status.c816.vp_n   = vpn_r;
            status.c816.vda    = vda_r;
            status.c816.ef     = ef_r;
            status.c816.rw_n   = rwn_r;
        end
    end

    assign push_rec_o.bank   = bank_r;
    assign push_rec_o.addr   = addr_r;
    assign push_rec_o.data   = data_r;
    assign push_rec_o.status = status;

endmodule

`default_nettype wire

/* src/trace_fifo.sv */
// circular trace buffer, keeps the newest records and drops the oldest when full
`timescale 1ns/100ps
`default_nettype none

`include "nora_trace_defines.svh"

module trace_fifo (
    input  wire                        clk6x,
    input  wire                        rst_n_i,
    input  wire                        push_i,
    input  nora_trace_pkg::trace_rec_t push_rec_i,
    trace_rd_if.buffer                 rd
);
    import nora_trace_pkg::*;

    trace_rec_t             mem [`TRACE_DEPTH];
    logic [`TRACE_PTR_W-1:0] wr_ptr;
    logic [`TRACE_PTR_W-1:0] rd_ptr;
    trace_level_t           count;
    logic                   full;
    logic                   do_pop;
    logic                   overwrite;

    assign full      = (count == trace_level_t'(`TRACE_DEPTH));
    assign do_pop    = rd.pop && !rd.empty;        // stray pop on empty ignored
    assign overwrite = push_i && full && !do_pop;  // oldest record lost

    // record store, no back-pressure on push
    always_ff @(posedge clk6x)
    begin
        if (push_i)
            mem[wr_ptr] <= push_rec_i;
    end

    always_ff @(posedge clk6x or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push_i)
                wr_ptr <= wr_ptr + 1'b1;    // wraps at depth
            if (do_pop || overwrite)
                rd_ptr <= rd_ptr + 1'b1;    // head moves with the writer on overflow

            // full + push keeps count at depth
            if (push_i && !do_pop && !full)
                count <= count + 1'b1;
            else if (do_pop && !push_i)
                count <= count - 1'b1;
        end
    end

    assign rd.rec   = mem[rd_ptr];  // head, meaningful while !empty
    assign rd.empty = (count == '0);
    assign rd.level = count;

endmodule

`default_nettype wire

/* src/trace_reader.sv */
// host side serializer, one record byte per read pulse, pops after the last byte
`timescale 1ns/100ps
`default_nettype none

`include "nora_trace_defines.svh"

module trace_reader (
    input  wire         clk6x,
    input  wire         rst_n_i,
    input  wire         rd_req_i,       // one cycle read pulse
    trace_rd_if.reader  rd,
    output logic [7:0]  byte_o,
    output logic        byte_valid_o
);
    localparam int IDX_W = $clog2(`TRACE_BYTES);

    logic [IDX_W-1:0] byte_idx;     // next byte of head record
    logic [7:0]       byte_sel;
    logic             last_byte;

    assign last_byte = (byte_idx == IDX_W'(`TRACE_BYTES - 1));

    // host byte order: status first, bank last
    always_comb
    begin
        case (byte_idx)
            3'd0:    byte_sel = rd.rec.status;
            3'd1:    byte_sel = rd.rec.data;
            3'd2:    byte_sel = rd.rec.addr[7:0];
            3'd3:    byte_sel = rd.rec.addr[15:8];
            3'd4:    byte_sel = rd.rec.bank;
            default: byte_sel = `EMPTY_READ_BYTE;
        endcase
    end

    always_ff @(posedge clk6x)
    begin
        if (rd_req_i)
            byte_o <= rd.empty ? `EMPTY_READ_BYTE : byte_sel;  // filler on empty
    end

    always_ff @(posedge clk6x or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            byte_idx     <= '0;
            byte_valid_o <= 1'b0;
            rd.pop       <= 1'b0;
        end
        else
        begin
            byte_valid_o <= rd_req_i;
            rd.pop       <= rd_req_i && !rd.empty && last_byte;  // with the bank byte
            if (rd_req_i && !rd.empty)
            begin
                if (last_byte)
                    byte_idx <= '0;     // next record starts at status
                else
                    byte_idx <= byte_idx + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* src/nora_trace_top.sv */
// cpu bus trace top: phaser, bus sampler, trace buffer and trace reader
`timescale 1ns/100ps
`default_nettype none

module nora_trace_top (
    input  wire                          clk6x,
    input  wire                          rst_n_i,
    input  wire                          run_i,         // run/stop request
    input  wire                          cputype02_i,   // 1 = 65C02 fitted
    // cpu bus
    input  wire  [15:0]                  cpu_ab_i,
    input  wire  [7:0]                   cpu_db_i,
    input  wire                          csob_mx_i,
    input  wire                          csync_vpa_i,
    input  wire                          cmln_i,
    input  wire                          cvpn_i,
    input  wire                          cvda_i,
    input  wire                          cef_i,
    input  wire                          crwn_i,
    // host read side
    input  wire                          rd_req_i,
    output logic                         cphi2_o,
    output logic [7:0]                   byte_o,
    output logic                         byte_valid_o,
    output nora_trace_pkg::trace_level_t trace_level_o
);
    import nora_trace_pkg::*;

    logic       latch_ad;       // phi2 rise
    logic       release_wr;     // end of cpu cycle
    logic       push;
    trace_rec_t push_rec;

    trace_rd_if rd_bus ();

    cpu_phaser phaser_i (
        .clk6x        (clk6x),
        .rst_n_i      (rst_n_i),
        .run_i        (run_i),
        .cphi2_o      (cphi2_o),
        .latch_ad_o   (latch_ad),
        .release_wr_o (release_wr)
    );

    cpu_bus_sampler sampler_i (
        .clk6x        (clk6x),
        .rst_n_i      (rst_n_i),
        .latch_ad_i   (latch_ad),
        .release_wr_i (release_wr),
        .cputype02_i  (cputype02_i),
        .cpu_ab_i     (cpu_ab_i),
        .cpu_db_i     (cpu_db_i),
        .csob_mx_i    (csob_mx_i),
        .csync_vpa_i  (csync_vpa_i),
        .cmln_i       (cmln_i),
        .cvpn_i       (cvpn_i),
        .cvda_i       (cvda_i),
        .cef_i        (cef_i),
        .crwn_i       (crwn_i),
        .push_o       (push),
        .push_rec_o   (push_rec)
    );

    trace_fifo fifo_i (
        .clk6x      (clk6x),
        .rst_n_i    (rst_n_i),
        .push_i     (push),
        .push_rec_i (push_rec),
        .rd         (rd_bus.buffer)
    );

    trace_reader reader_i (
        .clk6x        (clk6x),
        .rst_n_i      (rst_n_i),
        .rd_req_i     (rd_req_i),
        .rd           (rd_bus.reader),
        .byte_o       (byte_o),
        .byte_valid_o (byte_valid_o)
    );

    assign trace_level_o = rd_bus.level;    // fill count for the host

endmodule

`default_nettype wire

/* verification/tb_nora_trace_table.svh */
// cpu cycle stimulus rows with hand worked trace records, table length constants
`ifndef TB_NORA_TRACE_TABLE_SVH
`define TB_NORA_TRACE_TABLE_SVH

// st packs the pins from the top: sob_mx, sync_vpa, mln, vpn, vda, ef, rw_n
typedef struct packed {
    logic        c02;       // cputype02_i
    logic [15:0] ab;
    logic [7:0]  bank;      // on the data bus up to the address latch
    logic [7:0]  data;      // on the data bus after the latch
    logic [6:0]  st;
    trace_rec_t  exp;       // bank, addr, data, status
} row_t;

localparam int T3_FIRST = 0;        // 65C816 rows
localparam int T3_ROWS  = 5;
localparam int T4_FIRST = 5;        // 65C02 rows
localparam int T4_ROWS  = 4;
localparam int T5_FIRST = 9;        // overflow burst
localparam int T5_ROWS  = 11;
localparam int T6_FIRST = 20;       // record after an empty read
localparam int T6_ROWS  = 1;
localparam int N_ROWS   = 21;
// records read back, plus the single empty read
localparam int N_READ_BYTES = (T3_ROWS + T4_ROWS + `TRACE_DEPTH + T6_ROWS) * `TRACE_BYTES + 1;

// 816 status is {mx|ef, mx|ef, vpa, mln, vpn, vda, ef, rw_n}
// C02 status is {1, 1, sync, mln, vpn, 1, 1, rw_n} with bank 0
localparam row_t ROWS [N_ROWS] = '{
    '{1'b0, 16'h1234, 8'h01, 8'hA5, 7'b0111101, 40'h01_1234_A5_3D},
    '{1'b0, 16'h8000, 8'h7E, 8'h5A, 7'b1011100, 40'h7E_8000_5A_DC},   // write, m/x set
    '{1'b0, 16'hFFFC, 8'h00, 8'h00, 7'b0110111, 40'h00_FFFC_00_F7},   // vector pull in emulation
    '{1'b0, 16'h00FF, 8'h12, 8'h34, 7'b0001010, 40'h12_00FF_34_CA},
    '{1'b0, 16'h4321, 8'hC3, 8'h3C, 7'b1111001, 40'hC3_4321_3C_F9},
    '{1'b1, 16'hC000, 8'h55, 8'hEA, 7'b0111000, 40'h00_C000_EA_FE},   // bank pins ignored
    '{1'b1, 16'h0200, 8'hAA, 8'h42, 7'b1011011, 40'h00_0200_42_DF},
    '{1'b1, 16'hFFFE, 8'h0F, 8'h80, 7'b0010101, 40'h00_FFFE_80_D7},
    '{1'b1, 16'h01FD, 8'hF0, 8'h99, 7'b1001000, 40'h00_01FD_99_CE},
    '{1'b0, 16'h1001, 8'h01, 8'h11, 7'b0111101, 40'h01_1001_11_3D},   // rows 1..3 get lost
    '{1'b0, 16'h1002, 8'h02, 8'h22, 7'b0011100, 40'h02_1002_22_1C},
    '{1'b0, 16'h1003, 8'h03, 8'h33, 7'b0111101, 40'h03_1003_33_3D},
    '{1'b0, 16'h1004, 8'h04, 8'h44, 7'b0011100, 40'h04_1004_44_1C},
    '{1'b0, 16'h1005, 8'h05, 8'h55, 7'b0111101, 40'h05_1005_55_3D},
    '{1'b0, 16'h1006, 8'h06, 8'h66, 7'b0011100, 40'h06_1006_66_1C},
    '{1'b0, 16'h1007, 8'h07, 8'h77, 7'b0111101, 40'h07_1007_77_3D},
    '{1'b0, 16'h1008, 8'h08, 8'h88, 7'b0011100, 40'h08_1008_88_1C},
    '{1'b0, 16'h1009, 8'h09, 8'h99, 7'b0111101, 40'h09_1009_99_3D},
    '{1'b0, 16'h100A, 8'h0A, 8'hAA, 7'b0011100, 40'h0A_100A_AA_1C},
    '{1'b0, 16'h100B, 8'h0B, 8'hBB, 7'b0111101, 40'h0B_100B_BB_3D},
    '{1'b0, 16'h2468, 8'h80, 8'h13, 7'b1011111, 40'h80_2468_13_DF}
};

`endif

/* verification/tb_nora_trace.sv */
// testbench for the cpu bus trace path: clock, reset, table driven cpu cycles, host reads
`timescale 1ns/100ps
`default_nettype none

`include "nora_trace_defines.svh"

module tb_nora_trace;
    import nora_trace_pkg::*;

`include "tb_nora_trace_table.svh"

    localparam int CLK_HALF    = 20;    // 40 ns period
    localparam int RST_CYCLES  = 8;
    localparam int CYCLE_LIMIT = N_ROWS * `CPU_CYCLE_PHASES + N_READ_BYTES * 3 + 200;

    logic         clk6x;
    logic         rst_n_i;
    logic         run_i;
    logic         cputype02_i;
    logic [15:0]  cpu_ab_i;
    logic [7:0]   cpu_db_i;
    logic         csob_mx_i, csync_vpa_i, cmln_i, cvpn_i, cvda_i, cef_i, crwn_i;
    logic         rd_req_i;
    logic         cphi2_o;
    logic [7:0]   byte_o;
    logic         byte_valid_o;
    trace_level_t trace_level_o;

    int errors    = 0;
    int checks    = 0;
    int test_no   = 1;
    int test_err0 = 0;      // errors before the running test
    int cycle_cnt = 0;

    nora_trace_top dut_i (.*);

    initial
    begin
        clk6x = 1'b0;
        forever #CLK_HALF clk6x = ~clk6x;
    end

    // hard stop in case a strobe never shows up
    always @(posedge clk6x)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT)
        begin
            $display("timeout: run still busy after %0d clk6x cycles", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_level(input string name, input trace_level_t got,
                               input trace_level_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_rec(input string name, input trace_rec_t got, input trace_rec_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // enter and leave at a falling edge with the phaser parked in phase 0
    task automatic apply_rows(input int first, input int n);
        int i;
        for (i = first; i < first + n; i++)
        begin
            cputype02_i = ROWS[i].c02;
            cpu_ab_i    = ROWS[i].ab;
            cpu_db_i    = ROWS[i].bank;     // bank multiplexed on the data bus
            {csob_mx_i, csync_vpa_i, cmln_i, cvpn_i, cvda_i, cef_i, crwn_i} = ROWS[i].st;
            run_i       = 1'b1;
            do @(negedge clk6x); while (!cphi2_o);  // phase 3, latch pending
            @(negedge clk6x);                       // address and bank latched
            cpu_db_i = ROWS[i].data;
            do @(negedge clk6x); while (cphi2_o);   // cycle done, back in phase 0
        end
        run_i = 1'b0;
        repeat (2) @(negedge clk6x);    // last push reaches the buffer
    endtask

    // one read pulse, then an idle cycle, so pulses come 3 cycles apart
    task automatic read_byte(output logic [7:0] b);
        @(negedge clk6x);
        rd_req_i = 1'b1;
        @(negedge clk6x);
        rd_req_i = 1'b0;
        while (!byte_valid_o)
            @(negedge clk6x);
        b = byte_o;
        @(negedge clk6x);
        check_bit("byte_valid_o", byte_valid_o, 1'b0);  // single cycle strobe
    endtask

    task automatic read_back(input int first, input int n);
        logic [7:0] b [`TRACE_BYTES];
        trace_rec_t got;
        int         k;
        int         j;
        for (k = 0; k < n; k++)
        begin
            for (j = 0; j < `TRACE_BYTES; j++)
                read_byte(b[j]);
            got = {b[4], b[3], b[2], b[1], b[0]};    // status came first, bank last
            check_rec("trace record", got, ROWS[first + k].exp);
            if (ROWS[first + k].c02)
            begin
                check_byte("c02 bank", got.bank, 8'h00);
                check_byte("c02 status & C6", got.status & 8'hC6, 8'hC6);
            end
        end
        check_level("trace_level_o", trace_level_o, '0);
    endtask

    task automatic end_test(input string name);
        if (errors == test_err0)
            $display("test %0d %s: ok", test_no, name);
        else
            $display("test %0d %s: %0d errors", test_no, name, errors - test_err0);
        test_no++;
        test_err0 = errors;
    endtask

    initial
    begin
        logic [7:0] b;
        rst_n_i     = 1'b0;
        run_i       = 1'b0;
        cputype02_i = 1'b0;
        cpu_ab_i    = '0;
        cpu_db_i    = '0;
        {csob_mx_i, csync_vpa_i, cmln_i, cvpn_i, cvda_i, cef_i, crwn_i} = '0;
        rd_req_i    = 1'b0;
        repeat (RST_CYCLES) @(negedge clk6x);
        rst_n_i = 1'b1;
        @(negedge clk6x);

        check_bit("cphi2_o", cphi2_o, 1'b0);
        check_bit("byte_valid_o", byte_valid_o, 1'b0);
        check_level("trace_level_o", trace_level_o, '0);
        end_test("reset values");

        repeat (30)     // cpu held
        begin
            @(negedge clk6x);
            check_bit("cphi2_o", cphi2_o, 1'b0);
            check_level("trace_level_o", trace_level_o, '0);
        end
        end_test("run_i low parks the cpu");

        apply_rows(T3_FIRST, T3_ROWS);  // also shows run_i restarts the cpu
        check_level("trace_level_o", trace_level_o, trace_level_t'(T3_ROWS));
        read_back(T3_FIRST, T3_ROWS);
        end_test("65C816 records");

        apply_rows(T4_FIRST, T4_ROWS);
        check_level("trace_level_o", trace_level_o, trace_level_t'(T4_ROWS));
        read_back(T4_FIRST, T4_ROWS);
        end_test("65C02 forcing");

        apply_rows(T5_FIRST, T5_ROWS);
        check_level("trace_level_o", trace_level_o, trace_level_t'(`TRACE_DEPTH));
        read_back(T5_FIRST + T5_ROWS - `TRACE_DEPTH, `TRACE_DEPTH);    // newest eight
        end_test("overflow keeps newest");

        read_byte(b);
        check_byte("byte_o", b, `EMPTY_READ_BYTE);
        check_level("trace_level_o", trace_level_o, '0);
        apply_rows(T6_FIRST, T6_ROWS);
        read_back(T6_FIRST, T6_ROWS);   // must start at the status byte
        end_test("read on empty buffer");

        $display("summary: %0d tests, %0d checks, %0d errors", test_no - 1, checks, errors);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+src
+incdir+verification
src/nora_trace_pkg.sv
src/trace_rd_if.sv
src/cpu_phaser.sv
src/cpu_bus_sampler.sv
src/trace_fifo.sv
src/trace_reader.sv
src/nora_trace_top.sv
verification/tb_nora_trace.sv
